// ==== design/buf_read_ctrl.sv ====
// reads the line buffer into the W channel, wvalid two cycles after rd
// a page ends at line end, at word 127, or at the final word of the transfer
// the last word of a page waits for a second ready page unless it is the final word
`timescale 1ns/10ps
`default_nettype none

module buf_read_ctrl #(
    parameter int FRAME_WIDTH_BITS = 13
) (
    input  wire                                hclk,
    input  wire                                rst,
    input  wire                                started_i,
    input  wire                                enable_i,
    input  wire membridge_pkg::addr64_t        len64_i,
    input  wire [FRAME_WIDTH_BITS:0]           last_in_line_i,
    input  wire                                page_ready_i,
    input  wire                                page_reset_i,
    input  wire [7:0]                          wcount_i,
    page_buf_if.reader                         rd,
    output logic [membridge_pkg::DATA_BITS-1:0] wdata_o,
    output logic                               wvalid_o,
    output logic                               wlast_o,
    output logic                               next_page_o
);
    import membridge_pkg::*;

    logic                      page_ready_r, wd_safe;
    logic [2:0]                pages_ready;  // filled pages not yet returned
    logic [PAGE_SEL_BITS-1:0]  page;
    logic [FRAME_WIDTH_BITS:0] in_line;      // next word position in line
    addr64_t                   left64;       // words still to read
    logic [BURST_LOG2-1:0]     beat_cnt;
    logic [2:0]                rd_pipe, last_pipe;

    wire final_word   = left64 == addr64_t'(1);
    wire last_in_line = in_line == last_in_line_i;
    wire last_in_page = last_in_line || (&in_line[PAGE_LOG2-1:0]);
    wire rd_w         = started_i && wd_safe && (|left64) &&
                        ((|pages_ready[2:1]) ||
                         (pages_ready[0] && (!last_in_page || final_word)));
    wire next_w       = rd_w && (last_in_page || final_word);  // page handed back

    assign rd.rd    = rd_pipe[0];
    assign rd.regen = rd_pipe[1];
    assign wdata_o  = rd.rdata;
    assign wvalid_o = rd_pipe[2];
    assign wlast_o  = last_pipe[2];

    always_ff @(posedge hclk) begin
        if (rd_w) begin  // address registered for the ram read
            rd.page <= page;
            rd.word <= in_line[PAGE_LOG2-1:0];
        end
        last_pipe <= {last_pipe[1:0], (&beat_cnt) || final_word};
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            page_ready_r <= 1'b0;
            wd_safe      <= 1'b0;
            pages_ready  <= '0;
            page         <= '0;
            in_line      <= '0;
            left64       <= '0;
            beat_cnt     <= '0;
            rd_pipe      <= '0;
            next_page_o  <= 1'b0;
        end else begin
            page_ready_r <= page_ready_i;  // started is set by the same pulse
            wd_safe      <= enable_i && !wcount_i[7] && !(&wcount_i[6:3]);  // below ~120
            rd_pipe      <= {rd_pipe[1:0], rd_w};
            next_page_o  <= next_w;

            if (!started_i)                   pages_ready <= '0;
            else if (page_ready_r && !next_w) pages_ready <= pages_ready + 1'b1;
            else if (!page_ready_r && next_w) pages_ready <= pages_ready - 1'b1;

            if (page_reset_i)  page <= '0;
            else if (next_w)   page <= page + 1'b1;

            if (!started_i) begin
                in_line  <= '0;
                left64   <= len64_i;
                beat_cnt <= '0;
            end else if (rd_w) begin
                in_line  <= last_in_line ? '0 : in_line + 1'b1;
                left64   <= left64 - 1'b1;
                beat_cnt <= beat_cnt + 1'b1;  // bursts are 16 words except the last
            end
        end
    end
endmodule

`default_nettype wire

// ==== design/burst_addr_gen.sv ====
// rolling window address and AW issue, one burst per 3+ cycles
// the last burst may be partial and is not checked for rollover
`timescale 1ns/10ps
`default_nettype none

module burst_addr_gen (
    input  wire                    hclk,
    input  wire                    rst,
    input  wire                    start_i,
    input  wire                    keep_addr_i,
    input  wire                    enable_i,
    input  wire                    started_i,
    input  wire membridge_pkg::addr64_t lo_addr64_i,
    input  wire membridge_pkg::addr64_t size64_i,
    input  wire membridge_pkg::addr64_t start64_i,
    input  wire membridge_pkg::addr64_t len64_i,
    input  wire [5:0]              wacount_i,
    output membridge_pkg::addr64_t awaddr_o,  // relative to lo_addr64_i
    output logic [3:0]             awlen_o,
    output logic                   awvalid_o,
    output logic                   left_zero_o,
    output logic [7:0]             bursts_o
);
    import membridge_pkg::*;

    localparam int      ADV_DELAY   = 3;  // lets the registered flags settle
    localparam addr64_t BURST_WORDS = addr64_t'(1 << BURST_LOG2);

    addr64_t                          rel_addr;
    addr64_t                          left64;     // words not yet covered by AW
    logic [ADDR64_BITS-BURST_LOG2-1:0] last_blk;  // last block before rollover
    logic                             last_burst, rollover, low4_zero, wa_safe;
    logic [ADV_DELAY-1:0]             adv_d;

    wire adv_w = started_i && wa_safe && (|left64);

    assign awaddr_o    = rel_addr;  // holds during the awvalid pulse
    assign left_zero_o = low4_zero && last_burst;

    always_ff @(posedge hclk) begin
        last_blk   <= size64_i[ADDR64_BITS-1:BURST_LOG2] - 1'b1;
        last_burst <= !(|left64[ADDR64_BITS-1:BURST_LOG2]);
        low4_zero  <= !(|left64[BURST_LOG2-1:0]);
        rollover   <= rel_addr[ADDR64_BITS-1:BURST_LOG2] == last_blk;
        awlen_o    <= (|left64[ADDR64_BITS-1:BURST_LOG2]) ? 4'hf : left64[3:0] - 1'b1;

        if (start_i && !keep_addr_i) rel_addr <= start64_i;  // else keep end address
        else if (awvalid_o)          rel_addr <= last_burst ? rel_addr + left64[3:0] :
                                                 rollover   ? '0 : rel_addr + BURST_WORDS;

        if (start_i)        left64 <= len64_i;
        else if (awvalid_o) left64 <= last_burst ? '0 : left64 - BURST_WORDS;
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            awvalid_o <= 1'b0;
            adv_d     <= '0;
            wa_safe   <= 1'b0;
            bursts_o  <= '0;
        end else begin
            awvalid_o <= adv_w && !awvalid_o && !(|adv_d);
            adv_d     <= {adv_d[ADV_DELAY-2:0], awvalid_o};
            wa_safe   <= enable_i && !wacount_i[5] && !(&wacount_i[4:2]);  // below ~28
            if (!started_i)     bursts_o <= '0;
            else if (awvalid_o) bursts_o <= bursts_o + 1'b1;
        end
    end
endmodule

`default_nettype wire

// ==== design/line_buffer.sv ====
// four 128-word pages, producer writes words in order, page by page
// read data appears two cycles after rd (rd, then regen)
`timescale 1ns/10ps
`default_nettype none

module line_buffer (
    input  wire                                 hclk,
    input  wire                                 rst,
    input  wire                                 buf_wr_i,
    input  wire [membridge_pkg::DATA_BITS-1:0]  buf_wdata_i,
    input  wire                                 buf_page_next_i,
    input  wire                                 page_reset_i,
    page_buf_if.buffer                          rd
);
    import membridge_pkg::*;

    localparam int DEPTH = 1 << (PAGE_SEL_BITS + PAGE_LOG2);

    logic [DATA_BITS-1:0]     mem [0:DEPTH-1];
    logic [DATA_BITS-1:0]     ram_q;  // first read stage
    logic [PAGE_SEL_BITS-1:0] wpage;
    logic [PAGE_LOG2-1:0]     waddr;

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            wpage <= '0;
            waddr <= '0;
        end else if (page_reset_i) begin  // frame start
            wpage <= '0;
            waddr <= '0;
        end else if (buf_page_next_i) begin
            wpage <= wpage + 1'b1;
            waddr <= '0;
        end else if (buf_wr_i) begin
            waddr <= waddr + 1'b1;
        end
    end

    always_ff @(posedge hclk) begin
        if (buf_wr_i) mem[{wpage, waddr}] <= buf_wdata_i;
        if (rd.rd)    ram_q <= mem[{rd.page, rd.word}];
        if (rd.regen) rd.rdata <= ram_q;
    end
endmodule

`default_nettype wire

// ==== design/membridge_cfg_regs.sv ====
// config registers, lo/size/start forced to 16-word alignment
// start pulse comes one cycle after the ctrl write
`timescale 1ns/10ps
`default_nettype none

module membridge_cfg_regs #(
    parameter int FRAME_WIDTH_BITS = 13
) (
    input  wire                           hclk,
    input  wire                           rst,
    input  wire                           cfg_we_i,
    input  wire  [2:0]                    cfg_addr_i,
    input  wire  membridge_pkg::cfg_word_u cfg_data_i,
    output logic                          enable_o,
    output logic                          start_o,
    output logic                          keep_addr_o,
    output membridge_pkg::addr64_t        lo_addr64_o,
    output membridge_pkg::addr64_t        size64_o,
    output membridge_pkg::addr64_t        start64_o,
    output membridge_pkg::addr64_t        len64_o,
    output logic [FRAME_WIDTH_BITS:0]     last_in_line_o
);
    import membridge_pkg::*;

    logic [FRAME_WIDTH_BITS:0] width64;  // line width in words
    addr64_t                   aligned;  // data word cut to 16-word blocks

    wire set_ctrl  = cfg_we_i && (cfg_addr_i == REG_CTRL);
    wire set_lo    = cfg_we_i && (cfg_addr_i == REG_LO_ADDR64);
    wire set_size  = cfg_we_i && (cfg_addr_i == REG_SIZE64);
    wire set_start = cfg_we_i && (cfg_addr_i == REG_START64);
    wire set_len   = cfg_we_i && (cfg_addr_i == REG_LEN64);
    wire set_width = cfg_we_i && (cfg_addr_i == REG_WIDTH64);

    assign aligned = {cfg_data_i.word.addr[ADDR64_BITS-1:BURST_LOG2], {BURST_LOG2{1'b0}}};

    always_ff @(posedge hclk) begin
        if (set_lo)         lo_addr64_o <= aligned;
        if (set_size)       size64_o    <= aligned;
        if (set_lo)         start64_o   <= '0;  // new window restarts at its base
        else if (set_start) start64_o   <= aligned;
        if (set_len)        len64_o     <= cfg_data_i.word.addr;  // any length
        if (set_width)      width64     <= cfg_data_i.word.addr[FRAME_WIDTH_BITS:0];
        last_in_line_o <= width64 - 1'b1;  // last word index in a line
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            enable_o    <= 1'b0;
            start_o     <= 1'b0;
            keep_addr_o <= 1'b0;
        end else begin
            if (set_ctrl) begin
                enable_o    <= cfg_data_i.ctrl.enable;
                keep_addr_o <= cfg_data_i.ctrl.keep_addr;
            end
            start_o <= set_ctrl && cfg_data_i.ctrl.start;  // one-cycle pulse
        end
    end
endmodule

`default_nettype wire

// ==== design/membridge_pkg.sv ====
// shared widths, register map and config word layout of the memory bridge
// all addresses and lengths are counted in 64-bit words
`default_nettype none

package membridge_pkg;

    localparam int ADDR64_BITS   = 29;  // word address / length width
    localparam int BURST_LOG2    = 4;   // 16-word max burst
    localparam int PAGE_LOG2     = 7;   // 128 words per page
    localparam int PAGE_SEL_BITS = 2;   // four pages
    localparam int DATA_BITS     = 64;

    // register map, 3-bit address
    localparam logic [2:0] REG_CTRL      = 3'd0;
    localparam logic [2:0] REG_LO_ADDR64 = 3'd1;  // window base
    localparam logic [2:0] REG_SIZE64    = 3'd2;  // window size, rolls to base
    localparam logic [2:0] REG_START64   = 3'd3;  // start offset in window
    localparam logic [2:0] REG_LEN64     = 3'd4;  // total transfer length
    localparam logic [2:0] REG_WIDTH64   = 3'd5;  // scan line width

    typedef logic [ADDR64_BITS-1:0] addr64_t;

    // one register data word, read as ctrl bits or as a word address
    typedef union packed {
        struct packed {
            logic [28:0] rsvd;
            logic        keep_addr;  // continue from previous end address
            logic        start;
            logic        enable;
        } ctrl;
        struct packed {
            logic [2:0] rsvd;
            addr64_t    addr;
        } word;
    } cfg_word_u;

endpackage

`default_nettype wire

// ==== design/membridge_top.sv ====
// DDR-to-system write bridge, single clock, fixed ID and cache
// producer must keep at most four pages outstanding against next_page_o
`timescale 1ns/10ps
`default_nettype none

module membridge_top #(
    parameter int FRAME_WIDTH_BITS = 13
) (
    input  wire         hclk,
    input  wire         rst,
    input  wire         cfg_we_i,
    input  wire  [2:0]  cfg_addr_i,
    input  wire  [31:0] cfg_data_i,
    input  wire         buf_wr_i,
    input  wire  [63:0] buf_wdata_i,
    input  wire         buf_page_next_i,
    input  wire         page_ready_i,
    input  wire         page_reset_i,
    output logic        next_page_o,   // page credit back to producer
    output logic [31:0] awaddr_o,      // byte address
    output logic        awvalid_o,
    output logic [3:0]  awlen_o,
    output logic [5:0]  awid_o,
    output logic [1:0]  awsize_o,
    output logic [1:0]  awburst_o,
    output logic [3:0]  awcache_o,
    output logic [63:0] wdata_o,
    output logic        wvalid_o,
    output logic        wlast_o,
    output logic [7:0]  wstrb_o,
    input  wire         bvalid_i,
    output logic        bready_o,
    input  wire  [7:0]  wcount_i,      // W FIFO fill level
    input  wire  [5:0]  wacount_i,     // AW FIFO fill level
    output logic        busy_o,
    output logic        done_o
);
    import membridge_pkg::*;

    logic                      enable, start, keep_addr, started, left_zero;
    addr64_t                   lo_addr64, size64, start64, len64, rel_addr;
    logic [FRAME_WIDTH_BITS:0] last_in_line;
    logic [7:0]                bursts;

    page_buf_if pbuf ();

    assign awaddr_o  = {lo_addr64 + rel_addr, 3'b000};
    assign awid_o    = 6'h20;
    assign awsize_o  = 2'h3;  // 8 bytes per beat
    assign awburst_o = 2'h1;  // incr
    assign awcache_o = 4'h3;
    assign wstrb_o   = 8'hff;
    assign bready_o  = 1'b1;

    membridge_cfg_regs #(.FRAME_WIDTH_BITS(FRAME_WIDTH_BITS)) u_regs (
        .hclk, .rst, .cfg_we_i, .cfg_addr_i, .cfg_data_i,
        .enable_o(enable), .start_o(start), .keep_addr_o(keep_addr),
        .lo_addr64_o(lo_addr64), .size64_o(size64), .start64_o(start64),
        .len64_o(len64), .last_in_line_o(last_in_line));

    burst_addr_gen u_addr (
        .hclk, .rst, .start_i(start), .keep_addr_i(keep_addr), .enable_i(enable),
        .started_i(started), .lo_addr64_i(lo_addr64), .size64_i(size64),
        .start64_i(start64), .len64_i(len64), .wacount_i,
        .awaddr_o(rel_addr), .awlen_o, .awvalid_o, .left_zero_o(left_zero),
        .bursts_o(bursts));

    line_buffer u_buf (
        .hclk, .rst, .buf_wr_i, .buf_wdata_i, .buf_page_next_i, .page_reset_i, .rd(pbuf));

    buf_read_ctrl #(.FRAME_WIDTH_BITS(FRAME_WIDTH_BITS)) u_rdctl (
        .hclk, .rst, .started_i(started), .enable_i(enable), .len64_i(len64),
        .last_in_line_i(last_in_line), .page_ready_i, .page_reset_i, .wcount_i,
        .rd(pbuf), .wdata_o, .wvalid_o, .wlast_o, .next_page_o);

    xfer_sequencer u_seq (
        .hclk, .rst, .start_i(start), .enable_i(enable), .page_ready_i,
        .left_zero_i(left_zero), .bursts_i(bursts), .bvalid_i,
        .started_o(started), .busy_o, .done_o);
endmodule

`default_nettype wire

// ==== design/page_buf_if.sv ====
// read side of the line buffer, two-stage read (rd then regen)
`timescale 1ns/10ps
`default_nettype none

interface page_buf_if;
    import membridge_pkg::*;

    logic                     rd;     // ram read strobe
    logic                     regen;  // output register enable
    logic [PAGE_SEL_BITS-1:0] page;
    logic [PAGE_LOG2-1:0]     word;
    logic [DATA_BITS-1:0]     rdata;  // valid the cycle after regen

    modport reader (output rd, regen, page, word, input rdata);
    modport buffer (input rd, regen, page, word, output rdata);
endinterface

`default_nettype wire

// ==== design/xfer_sequencer.sv ====
// transfer state, B response count and done
// done rises on the edge busy_o falls, cleared by start or by enable low
`timescale 1ns/10ps
`default_nettype none

module xfer_sequencer (
    input  wire       hclk,
    input  wire       rst,
    input  wire       start_i,
    input  wire       enable_i,
    input  wire       page_ready_i,
    input  wire       left_zero_i,
    input  wire [7:0] bursts_i,
    input  wire       bvalid_i,
    output logic      started_o,
    output logic      busy_o,
    output logic      done_o
);
    logic       busy_r, bvalid_r, over, pre_done;
    logic [7:0] bresp_cnt;  // bursts confirmed on B

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            busy_r    <= 1'b0;
            started_o <= 1'b0;
            bvalid_r  <= 1'b0;
            bresp_cnt <= '0;
            over      <= 1'b0;
            busy_o    <= 1'b0;
            pre_done  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            if (start_i)   busy_r <= 1'b1;
            else if (over) busy_r <= 1'b0;

            if (!busy_r)           started_o <= 1'b0;
            else if (page_ready_i) started_o <= 1'b1;  // first page in the buffer

            bvalid_r <= bvalid_i;
            if (!busy_r)        bresp_cnt <= '0;
            else if (bvalid_r)  bresp_cnt <= bresp_cnt + 1'b1;

            over     <= left_zero_i && (bursts_i == bresp_cnt) && started_o;
            busy_o   <= busy_r;
            pre_done <= busy_r && over;  // lines done up with busy_o falling

            if (!enable_i)     done_o <= 1'b0;
            else if (pre_done) done_o <= 1'b1;
            else if (start_i)  done_o <= 1'b0;
        end
    end
endmodule

`default_nettype wire

// ==== dv/membridge_tb.sv ====
// testbench for membridge_top with a page-credit producer, an AXI write sink and random FIFO levels
// outputs sampled on the falling edge and inputs driven 1 ns after the rising edge
// every run starts at in-line position 0 and pulses page_reset_i first
`timescale 1ns/10ps
`default_nettype none

module membridge_tb;
    import membridge_pkg::*;

    localparam int CLK_NS      = 8;
    localparam int TOTAL_WORDS = 64 + 700 + 70 + 80 + 40 + 500;  // all runs below
    localparam int LIMIT_NS    = (TOTAL_WORDS * 12 + 6 * 300) * CLK_NS;

    logic        hclk, rst, cfg_we_i, buf_wr_i, buf_page_next_i, page_ready_i, page_reset_i;
    logic [2:0]  cfg_addr_i;
    logic [31:0] cfg_data_i, awaddr_o, rnd;
    logic [63:0] buf_wdata_i, wdata_o;
    logic        next_page_o, awvalid_o, wvalid_o, wlast_o, bvalid_i, bready_o, busy_o, done_o;
    logic [3:0]  awlen_o, awcache_o;
    logic [5:0]  awid_o, wacount_i;
    logic [1:0]  awsize_o, awburst_o;
    logic [7:0]  wstrb_o, wcount_i, b_pipe;
    logic [5:0]  wa_hist [0:1];  // AW level seen on previous falling edges
    logic [7:0]  w_hist [0:3];   // W level seen on previous falling edges
    logic [5:0]  awid_first;     // id of the first burst, all others match it
    logic [3:0]  awcache_first;
    bit          aw_seen;

    integer seed = 32'hb9b7cf34;
    int     mismatches, other_errs, checks;
    int     credits, pages_made, b_sent, n_bursts;
    int     lo_reg, size_reg, start_reg, rel_model;  // window as the tb wrote it
    bit     bp_mode;                                 // random FIFO levels on

    logic [31:0] exp_addr_q[$];
    logic [3:0]  exp_len_q[$];
    logic [63:0] exp_data_q[$];
    logic        exp_last_q[$];

    membridge_top #(.FRAME_WIDTH_BITS(13)) dut0 (
        .hclk, .rst, .cfg_we_i, .cfg_addr_i, .cfg_data_i,
        .buf_wr_i, .buf_wdata_i, .buf_page_next_i, .page_ready_i, .page_reset_i,
        .next_page_o, .awaddr_o, .awvalid_o, .awlen_o, .awid_o, .awsize_o, .awburst_o,
        .awcache_o, .wdata_o, .wvalid_o, .wlast_o, .wstrb_o, .bvalid_i, .bready_o,
        .wcount_i, .wacount_i, .busy_o, .done_o);

    initial begin
        hclk = 1'b0;
        forever #(CLK_NS / 2) hclk = ~hclk;
    end

    function automatic logic [63:0] data_word(input int tid, input int idx);
        return {tid[15:0], 16'hbeef ^ idx[15:0], idx};  // unique per run and word
    endfunction

    // relative address of the burst after one of rem remaining words
    function automatic int ref_next_rel(input int rel, input int rem, input int size);
        if (rem < 16)
            return rel + rem;  // partial last burst has no wrap test
        if ((rel >> 4) == (size >> 4) - 1)
            return 0;          // last block below size rolls back to lo
        return rel + 16;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic expect_xfer(input int len, input int tid);
        int rem, blen, idx, b;
        rem      = len;
        idx      = 0;
        n_bursts = 0;
        while (rem > 0) begin
            blen = (rem < 16) ? rem : 16;
            exp_addr_q.push_back(32'((lo_reg + rel_model) * 8));  // byte address
            exp_len_q.push_back(4'(blen - 1));
            for (b = 0; b < blen; b++) begin
                exp_data_q.push_back(data_word(tid, idx));
                exp_last_q.push_back(b == blen - 1);
                idx++;
            end
            rel_model = ref_next_rel(rel_model, rem, size_reg);
            rem       -= blen;
            n_bursts++;
        end
    endtask

    task automatic cfg_write(input logic [2:0] addr, input logic [31:0] data);
        @(posedge hclk);
        #1;
        cfg_we_i   = 1'b1;
        cfg_addr_i = addr;
        cfg_data_i = data;
        @(posedge hclk);
        #1;
        cfg_we_i = 1'b0;
    endtask

    task automatic set_window(input int lo, input int size, input int start);
        cfg_write(REG_LO_ADDR64, lo);  // clears start, so start goes last
        cfg_write(REG_SIZE64, size);
        cfg_write(REG_START64, start);
        lo_reg    = lo;
        size_reg  = size;
        start_reg = start;
    endtask

    task automatic produce(input int len, input int width, input int tid);
        int idx;
        int pos;       // in-line position
        bit page_end;
        idx        = 0;
        pos        = 0;
        pages_made = 0;
        @(posedge hclk);
        #1 page_reset_i = 1'b1;  // both page pointers back to 0
        @(posedge hclk);
        #1 page_reset_i = 1'b0;
        while (idx < len) begin
            while (pages_made - credits >= 4) begin  // all four pages out
                @(posedge hclk);
                #1;
            end
            page_end = 1'b0;
            while (!page_end) begin
                buf_wr_i    = 1'b1;
                buf_wdata_i = data_word(tid, idx);
                page_end    = (pos % 128 == 127) || (pos == width - 1) || (idx == len - 1);
                idx++;
                pos = (pos == width - 1) ? 0 : pos + 1;
                @(posedge hclk);
                #1;
            end
            buf_wr_i        = 1'b0;
            buf_page_next_i = 1'b1;  // advance write page
            page_ready_i    = 1'b1;  // and hand it over
            pages_made++;
            @(posedge hclk);
            #1;
            buf_page_next_i = 1'b0;
            page_ready_i    = 1'b0;
        end
    endtask

    task automatic run_xfer(input int len, input int width, input bit keep, input bit bp,
                            input int tid);
        bp_mode = bp;
        if (!keep)
            rel_model = start_reg;  // reload from start64
        expect_xfer(len, tid);
        credits = 0;
        b_sent  = 0;
        cfg_write(REG_WIDTH64, width);
        cfg_write(REG_LEN64, len);
        if (tid > 0)
            check("done_o before start", done_o, 1);  // held through other writes
        cfg_write(REG_CTRL, {29'd0, keep, 1'b1, 1'b1});  // enable + start
        wait (busy_o === 1'b1);
        check("done_o at busy rise", done_o, 0);
        produce(len, width, tid);
        wait (done_o === 1'b1);
        check("b responses at done", b_sent, n_bursts);
        check("aw bursts missing", exp_addr_q.size(), 0);
        check("w beats missing", exp_data_q.size(), 0);
        check("page credits", credits, pages_made);
    endtask

    // sink, level history and protocol checks
    always @(negedge hclk) begin
        if (!rst && awvalid_o) begin
            if (wa_hist[1] >= 6'd28) begin  // level sampled two edges before
                other_errs++;
                $display("error at %0t: AW burst issued while the address FIFO was full", $time);
            end
            if (exp_addr_q.size() == 0) begin
                other_errs++;
                $display("error at %0t: AW burst that no transfer expects", $time);
            end else begin
                check("awaddr_o", awaddr_o, exp_addr_q.pop_front());
                check("awlen_o", awlen_o, exp_len_q.pop_front());
            end
            check("awsize_o", awsize_o, 2'd3);     // 8-byte beats
            check("awburst_o", awburst_o, 2'd1);  // incrementing
            if ($isunknown({awid_o, awcache_o})) begin
                other_errs++;
                $display("error at %0t: AW id or cache field is undefined", $time);
            end
            if (!aw_seen) begin
                awid_first    = awid_o;
                awcache_first = awcache_o;
                aw_seen       = 1'b1;
            end
            check("awid_o", awid_o, awid_first);
            check("awcache_o", awcache_o, awcache_first);
        end
        if (!rst && wvalid_o) begin
            if (w_hist[3] >= 8'd120) begin  // four edges of read pipeline
                other_errs++;
                $display("error at %0t: W beat issued while the data FIFO was full", $time);
            end
            if (exp_data_q.size() == 0) begin
                other_errs++;
                $display("error at %0t: W beat that no transfer expects", $time);
            end else begin
                check("wdata_o", wdata_o, exp_data_q.pop_front());
                check("wlast_o", wlast_o, exp_last_q.pop_front());
            end
            check("wstrb_o", wstrb_o, 8'hff);  // full 64-bit words only
        end
        if (!rst && bvalid_i)
            check("bready_o", bready_o, 1'b1);
        if (!rst && next_page_o)
            credits++;
        if (busy_o && done_o) begin
            other_errs++;
            $display("error at %0t: busy_o and done_o are high together", $time);
        end
        b_pipe     = {b_pipe[6:0], wvalid_o && wlast_o};  // B a few cycles after wlast
        wa_hist[1] = wa_hist[0];
        wa_hist[0] = wacount_i;
        w_hist[3]  = w_hist[2];
        w_hist[2]  = w_hist[1];
        w_hist[1]  = w_hist[0];
        w_hist[0]  = wcount_i;
    end

    always @(posedge hclk) begin
        #1;
        bvalid_i = b_pipe[3];
        if (b_pipe[3])
            b_sent++;
        rnd       = $random(seed);
        wacount_i = bp_mode ? rnd[5:0] : 6'd0;
        wcount_i  = bp_mode ? rnd[15:8] : 8'd0;
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout: transfers did not finish within %0d ns", LIMIT_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        rst             = 1'b1;
        cfg_we_i        = 1'b0;
        cfg_addr_i      = '0;
        cfg_data_i      = '0;
        buf_wr_i        = 1'b0;
        buf_wdata_i     = '0;
        buf_page_next_i = 1'b0;
        page_ready_i    = 1'b0;
        page_reset_i    = 1'b0;
        bvalid_i        = 1'b0;
        wcount_i        = '0;
        wacount_i       = '0;
        b_pipe          = '0;
        wa_hist         = '{default: '0};
        w_hist          = '{default: '0};
        bp_mode         = 1'b0;
        repeat (3) @(posedge hclk);
        #1 rst = 1'b0;
        check("awvalid_o", awvalid_o, 0);  // idle outputs after reset
        check("wvalid_o", wvalid_o, 0);
        check("next_page_o", next_page_o, 0);
        check("busy_o", busy_o, 0);
        check("done_o", done_o, 0);

        set_window(32'h1000, 4096, 0);
        run_xfer(64, 300, 0, 0, 0);   // single aligned transfer
        run_xfer(700, 300, 0, 0, 1);  // across lines and partial pages
        run_xfer(70, 300, 0, 0, 2);   // 16,16,16,16,6
        set_window(32'h1800, 48, 32);
        run_xfer(80, 300, 0, 0, 3);   // wraps after block at 32
        run_xfer(40, 300, 1, 0, 4);   // continues from previous end
        set_window(32'h2000, 256, 64);
        run_xfer(500, 200, 0, 1, 5);  // random FIFO levels
        repeat (4) @(posedge hclk);

        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end
endmodule

`default_nettype wire

// ==== verilog.f ====
design/membridge_pkg.sv
design/page_buf_if.sv
design/membridge_cfg_regs.sv
design/burst_addr_gen.sv
design/line_buffer.sv
design/buf_read_ctrl.sv
design/xfer_sequencer.sv
design/membridge_top.sv
dv/membridge_tb.sv
